//--- flist.f
cce_pkg.sv
cce_req_stage.sv
cce_resp_stage.sv
cce_uncached.sv
cce_tb_mem.sv
cce_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the uncached CCE testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f flist.f --top-module cce_tb -o cce_tb_sim \
  && { ./obj_dir/cce_tb_sim | tee /dev/stderr | grep -q "RESULT: PASS"; } \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- cce_tb.sv
// Testbench top for the uncached CCE: clock, reset, stimulus, scoreboard, assertions, result
`timescale 1ns/100ps
`default_nettype none

module cce_tb;

  logic clk_i = 1'b0;
  logic reset_i;
  logic hold;
  logic rand_ready;
  cce_pkg::cce_id_t   cce_id_i;
  logic               cfg_w_v_i;
  cce_pkg::cfg_addr_t cfg_addr_i;
  cce_pkg::cfg_data_t cfg_data_i;
  cce_pkg::lce_req_s  lce_req_i;
  logic               lce_req_v_i;
  logic               lce_req_yumi_o;
  cce_pkg::lce_cmd_s  lce_cmd_o;
  logic               lce_cmd_v_o;
  logic               lce_cmd_ready_i;
  cce_pkg::mem_cmd_s  mem_cmd_o;
  logic               mem_cmd_v_o;
  logic               mem_cmd_ready_i;
  cce_pkg::mem_resp_s mem_resp_i;
  logic               mem_resp_v_i;
  logic               mem_resp_yumi_o;

  int errors = 0;
  int cmds_seen = 0;
  int cycles = 0;
  int outstanding = 0;
  logic mode_exp;
  cce_pkg::dword_t   shadow [64];
  cce_pkg::lce_req_s req_q[$];
  cce_pkg::lce_cmd_s exp_q[4][$];

  always #2 clk_i = ~clk_i;

  cce_uncached #(.max_outstanding_p(4)) u_cce_uncached
    (.clk_i(clk_i), .reset_i(reset_i), .cce_id_i(cce_id_i)
     , .cfg_w_v_i(cfg_w_v_i), .cfg_addr_i(cfg_addr_i), .cfg_data_i(cfg_data_i)
     , .lce_req_i(lce_req_i), .lce_req_v_i(lce_req_v_i), .lce_req_yumi_o(lce_req_yumi_o)
     , .lce_cmd_o(lce_cmd_o), .lce_cmd_v_o(lce_cmd_v_o), .lce_cmd_ready_i(lce_cmd_ready_i)
     , .mem_cmd_o(mem_cmd_o), .mem_cmd_v_o(mem_cmd_v_o), .mem_cmd_ready_i(mem_cmd_ready_i)
     , .mem_resp_i(mem_resp_i), .mem_resp_v_i(mem_resp_v_i), .mem_resp_yumi_o(mem_resp_yumi_o));

  cce_tb_mem u_mem
    (.clk_i(clk_i), .reset_i(reset_i), .hold_i(hold)
     , .mem_cmd_i(mem_cmd_o), .mem_cmd_v_i(mem_cmd_v_o), .mem_cmd_ready_o(mem_cmd_ready_i)
     , .mem_resp_o(mem_resp_i), .mem_resp_v_o(mem_resp_v_i), .mem_resp_yumi_i(mem_resp_yumi_o));

  // Protocol checks
  a_cmd_after_yumi: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_req_yumi_o |=> mem_cmd_v_o)
    else begin errors++; $display("Error at %0t: no mem_cmd after yumi", $time); end
  a_mem_cmd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_cmd_v_o && !mem_cmd_ready_i |=> mem_cmd_v_o && $stable(mem_cmd_o))
    else begin errors++; $display("Error at %0t: stalled mem_cmd changed", $time); end
  a_lce_cmd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    lce_cmd_v_o && !lce_cmd_ready_i |=> lce_cmd_v_o && $stable(lce_cmd_o))
    else begin errors++; $display("Error at %0t: stalled lce_cmd changed", $time); end
  a_credit: assert property (@(posedge clk_i) disable iff (reset_i) outstanding <= 4)
    else begin errors++; $display("Error at %0t: %0d outstanding", $time, outstanding); end
  a_mode: assert property (@(posedge clk_i) disable iff (reset_i)
    mode_exp |-> !lce_req_yumi_o)
    else begin errors++; $display("Error at %0t: yumi in normal mode", $time); end
  a_reset: assert property (@(posedge clk_i) reset_i |=>
    !(lce_req_yumi_o || mem_resp_yumi_o || mem_cmd_v_o || lce_cmd_v_o))
    else begin errors++; $display("Error at %0t: output high after reset", $time); end

  // Scoreboard, values taken before the edge
  always @(posedge clk_i) begin
    cce_pkg::lce_req_s r;
    cce_pkg::lce_cmd_s e;
    cce_pkg::mem_msg_e exp_msg;
    logic found;
    if (reset_i) begin
      mode_exp <= 1'b0;
    end else begin
      if (cfg_w_v_i && cfg_addr_i == 16'h0008) mode_exp <= cfg_data_i[0];
      if (lce_req_v_i && lce_req_yumi_o) req_q.push_back(lce_req_i);
      if (mem_cmd_v_o && mem_cmd_ready_i) begin
        r = req_q.pop_front();
        exp_msg = (r.msg_type == cce_pkg::e_lce_req_uc_store) ? cce_pkg::e_mem_uc_wr
                                                              : cce_pkg::e_mem_uc_rd;
        assert (mem_cmd_o.addr == r.addr && mem_cmd_o.payload == r.src_id
                && mem_cmd_o.msg == exp_msg
                && (r.msg_type == cce_pkg::e_lce_req_uc_load || mem_cmd_o.data == r.data))
          else begin errors++; $display("Error at %0t: mem_cmd mismatch", $time); end
        e.dst_id = r.src_id;
        e.src_id = cce_id_i;
        e.addr = r.addr;
        if (r.msg_type == cce_pkg::e_lce_req_uc_store) begin
          shadow[r.addr[8:3]] = r.data;
          e.msg_type = cce_pkg::e_lce_cmd_uc_st_done;
          e.data = '0;
        end else begin
          e.msg_type = cce_pkg::e_lce_cmd_uc_data;
          e.data = shadow[r.addr[8:3]];
        end
        exp_q[r.src_id].push_back(e);
      end
      outstanding <= outstanding + int'(mem_cmd_v_o && mem_cmd_ready_i)
                     - int'(mem_resp_yumi_o);
      if (lce_cmd_v_o && lce_cmd_ready_i) begin
        found = 1'b0;
        cmds_seen++;
        for (int i = 0; i < exp_q[lce_cmd_o.dst_id].size(); i++) begin
          if (!found && exp_q[lce_cmd_o.dst_id][i] == lce_cmd_o) begin
            exp_q[lce_cmd_o.dst_id].delete(i);
            found = 1'b1;
          end
        end
        assert (found)
          else begin errors++; $display("Error at %0t: unexpected lce_cmd %h", $time, lce_cmd_o); end
      end
    end
  end

  always @(negedge clk_i) begin
    lce_cmd_ready_i = rand_ready ? logic'($urandom_range(0, 1)) : 1'b1;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= 20000) begin
      $display("Timeout: run stopped after %0d cycles with work still pending", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  function automatic cce_pkg::lce_req_s make_req();
    cce_pkg::lce_req_s r;
    r.src_id = cce_pkg::lce_id_t'($urandom_range(0, 3));
    r.msg_type = cce_pkg::lce_req_type_e'($urandom_range(0, 1));
    r.addr = $urandom;
    r.addr[8:3] = 6'($urandom_range(0, 7));
    r.addr[2:0] = 3'b0;
    r.data = {$urandom, $urandom};
    return r;
  endfunction

  task automatic send_req(input cce_pkg::lce_req_s req);
    lce_req_i = req;
    lce_req_v_i = 1'b1;
    do @(posedge clk_i); while (!lce_req_yumi_o);
    @(negedge clk_i);
    lce_req_v_i = 1'b0;
  endtask

  task automatic cfg_write(input cce_pkg::cfg_addr_t addr, input cce_pkg::cfg_data_t data);
    cfg_w_v_i = 1'b1;
    cfg_addr_i = addr;
    cfg_data_i = data;
    @(negedge clk_i);
    cfg_w_v_i = 1'b0;
  endtask

  task automatic drain();
    while (outstanding != 0 || req_q.size() != 0 || exp_q[0].size() != 0
           || exp_q[1].size() != 0 || exp_q[2].size() != 0 || exp_q[3].size() != 0) begin
      @(negedge clk_i);
    end
    repeat (4) @(negedge clk_i);
  endtask

  initial begin
    void'($urandom(32'h8bbde35d));
    for (int i = 0; i < 64; i++) begin
      shadow[i] = {26'h2a5a5a5, i[5:0], 26'h13c0de1, ~i[5:0]};
    end
    reset_i = 1'b1;
    hold = 1'b0;
    rand_ready = 1'b0;
    cce_id_i = 2'd2;
    cfg_w_v_i = 1'b0;
    cfg_addr_i = '0;
    cfg_data_i = '0;
    lce_req_i = '0;
    // A request waits through reset and must not be taken
    lce_req_v_i = 1'b1;
    lce_cmd_ready_i = 1'b1;
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;
    lce_req_v_i = 1'b0;
    @(negedge clk_i);
    repeat (40) send_req(make_req());
    // Random ready on both outputs
    @(posedge clk_i);
    rand_ready = 1'b1;
    @(negedge clk_i);
    repeat (100) send_req(make_req());
    drain();
    hold = 1'b1;
    fork
      repeat (8) send_req(make_req());
      begin
        repeat (30) @(negedge clk_i);
        hold = 1'b0;
      end
    join
    drain();
    cfg_write(16'h0008, 32'd1);
    lce_req_i = make_req();
    lce_req_v_i = 1'b1;
    repeat (10) @(negedge clk_i);
    cfg_write(16'h0010, 32'd0);
    repeat (10) @(negedge clk_i);
    lce_req_v_i = 1'b0;
    cfg_write(16'h0008, 32'd0);
    send_req(make_req());
    repeat (10) send_req(make_req());
    drain();
    $display("Errors: %0d, lce commands checked: %0d", errors, cmds_seen);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- cce_tb_mem.sv
// Memory model for the uncached CCE testbench: backing array, random response delay, hold switch
`timescale 1ns/100ps
`default_nettype none

module cce_tb_mem
  (input  logic                clk_i
   , input  logic              reset_i
   , input  logic              hold_i

   , input  cce_pkg::mem_cmd_s mem_cmd_i
   , input  logic              mem_cmd_v_i
   , output logic              mem_cmd_ready_o

   , output cce_pkg::mem_resp_s mem_resp_o
   , output logic              mem_resp_v_o
   , input  logic              mem_resp_yumi_i
  );

  cce_pkg::dword_t    mem [64];
  cce_pkg::mem_resp_s pend_q[$];
  int                 wait_q[$];
  cce_pkg::mem_cmd_s  cmd_r;
  logic               cmd_fire;
  logic               resp_fire;
  logic               reset_r;
  logic               hold_r;

  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = {26'h2a5a5a5, i[5:0], 26'h13c0de1, ~i[5:0]};
    end
    mem_cmd_ready_o = 1'b0;
    mem_resp_v_o = 1'b0;
    mem_resp_o = '0;
  end

  // Handshakes, reset and hold seen at the rising edge
  always @(posedge clk_i) begin
    cmd_fire <= mem_cmd_v_i & mem_cmd_ready_o;
    resp_fire <= mem_resp_v_o & mem_resp_yumi_i;
    cmd_r <= mem_cmd_i;
    reset_r <= reset_i;
    hold_r <= hold_i;
  end

  always @(negedge clk_i) begin
    cce_pkg::mem_resp_s r;
    if (reset_r) begin
      pend_q.delete();
      wait_q.delete();
      mem_resp_v_o = 1'b0;
      mem_cmd_ready_o = 1'b0;
    end else begin
      if (resp_fire) begin
        mem_resp_v_o = 1'b0;
      end
      if (cmd_fire) begin
        r.msg = cmd_r.msg;
        r.addr = cmd_r.addr;
        r.payload = cmd_r.payload;
        if (cmd_r.msg == cce_pkg::e_mem_uc_wr) begin
          mem[cmd_r.addr[8:3]] = cmd_r.data;
          r.data = cmd_r.data;
        end else begin
          r.data = mem[cmd_r.addr[8:3]];
        end
        pend_q.push_back(r);
        wait_q.push_back($urandom_range(0, 5));
      end
      foreach (wait_q[i]) begin
        if (wait_q[i] > 0) wait_q[i]--;
      end
      // First expired entry goes out, so order may change
      if (!mem_resp_v_o && !hold_r) begin
        for (int i = 0; i < wait_q.size(); i++) begin
          if (wait_q[i] == 0) begin
            mem_resp_o = pend_q[i];
            mem_resp_v_o = 1'b1;
            pend_q.delete(i);
            wait_q.delete(i);
            break;
          end
        end
      end
      mem_cmd_ready_o = ($urandom_range(0, 3) != 0);
    end
  end

endmodule

`default_nettype wire

//--- cce_uncached.sv
// Uncached CCE top level joining the request and response stages
`timescale 1ns/100ps
`default_nettype none

module cce_uncached
  #(parameter int max_outstanding_p = 4)
  (input  logic                 clk_i
   , input  logic               reset_i

   , input  cce_pkg::cce_id_t   cce_id_i

   // Config write
   , input  logic               cfg_w_v_i
   , input  cce_pkg::cfg_addr_t cfg_addr_i
   , input  cce_pkg::cfg_data_t cfg_data_i

   // LCE side
   , input  cce_pkg::lce_req_s  lce_req_i
   , input  logic               lce_req_v_i
   , output logic               lce_req_yumi_o

   , output cce_pkg::lce_cmd_s  lce_cmd_o
   , output logic               lce_cmd_v_o
   , input  logic               lce_cmd_ready_i

   // Memory side
   , output cce_pkg::mem_cmd_s  mem_cmd_o
   , output logic               mem_cmd_v_o
   , input  logic               mem_cmd_ready_i

   , input  cce_pkg::mem_resp_s mem_resp_i
   , input  logic               mem_resp_v_i
   , output logic               mem_resp_yumi_o
  );

  logic resp_done;

  cce_req_stage
    #(.max_outstanding_p(max_outstanding_p))
    u_req_stage
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.cfg_w_v_i(cfg_w_v_i)
      ,.cfg_addr_i(cfg_addr_i)
      ,.cfg_data_i(cfg_data_i)
      ,.lce_req_i(lce_req_i)
      ,.lce_req_v_i(lce_req_v_i)
      ,.lce_req_yumi_o(lce_req_yumi_o)
      ,.mem_cmd_o(mem_cmd_o)
      ,.mem_cmd_v_o(mem_cmd_v_o)
      ,.mem_cmd_ready_i(mem_cmd_ready_i)
      ,.resp_done_i(resp_done)
      );

  cce_resp_stage
    u_resp_stage
     (.clk_i(clk_i)
      ,.reset_i(reset_i)
      ,.cce_id_i(cce_id_i)
      ,.mem_resp_i(mem_resp_i)
      ,.mem_resp_v_i(mem_resp_v_i)
      ,.mem_resp_yumi_o(mem_resp_yumi_o)
      ,.lce_cmd_o(lce_cmd_o)
      ,.lce_cmd_v_o(lce_cmd_v_o)
      ,.lce_cmd_ready_i(lce_cmd_ready_i)
      ,.resp_done_o(resp_done)
      );

endmodule

`default_nettype wire

//--- cce_resp_stage.sv
// Response stage: memory response intake and LCE command register
`timescale 1ns/100ps
`default_nettype none

module cce_resp_stage
  (input  logic                 clk_i
   , input  logic               reset_i

   , input  cce_pkg::cce_id_t   cce_id_i

   // Memory responses, valid->yumi
   , input  cce_pkg::mem_resp_s mem_resp_i
   , input  logic               mem_resp_v_i
   , output logic               mem_resp_yumi_o

   // LCE commands, ready&valid
   , output cce_pkg::lce_cmd_s  lce_cmd_o
   , output logic               lce_cmd_v_o
   , input  logic               lce_cmd_ready_i

   // Credit return to the request stage
   , output logic               resp_done_o
  );

  cce_pkg::lce_cmd_s lce_cmd_n;
  logic              slot_free;

  assign slot_free = ~lce_cmd_v_o | lce_cmd_ready_i;
  assign mem_resp_yumi_o = ~reset_i & mem_resp_v_i & slot_free;
  assign resp_done_o = mem_resp_yumi_o;

  // Responses carry the requester id, so order does not matter
  always_comb begin
    lce_cmd_n.dst_id = mem_resp_i.payload;
    lce_cmd_n.src_id = cce_id_i;
    lce_cmd_n.addr = mem_resp_i.addr;
    if (mem_resp_i.msg == cce_pkg::e_mem_uc_rd) begin
      lce_cmd_n.msg_type = cce_pkg::e_lce_cmd_uc_data;
      lce_cmd_n.data = mem_resp_i.data;
    end else begin
      // Store acknowledge has no data
      lce_cmd_n.msg_type = cce_pkg::e_lce_cmd_uc_st_done;
      lce_cmd_n.data = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lce_cmd_v_o <= 1'b0;
    end else if (mem_resp_yumi_o) begin
      lce_cmd_v_o <= 1'b1;
    end else if (lce_cmd_ready_i) begin
      lce_cmd_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_resp_yumi_o) begin
      lce_cmd_o <= lce_cmd_n;
    end
  end

endmodule

`default_nettype wire

//--- cce_req_stage.sv
// Request stage: mode register, LCE request intake, memory command register, outstanding count
`timescale 1ns/100ps
`default_nettype none

module cce_req_stage
  #(parameter int max_outstanding_p = 4)
  (input  logic                clk_i
   , input  logic              reset_i

   // Config write, valid only
   , input  logic              cfg_w_v_i
   , input  cce_pkg::cfg_addr_t cfg_addr_i
   , input  cce_pkg::cfg_data_t cfg_data_i

   // LCE requests, valid->yumi
   , input  cce_pkg::lce_req_s lce_req_i
   , input  logic              lce_req_v_i
   , output logic              lce_req_yumi_o

   // Memory commands, ready&valid
   , output cce_pkg::mem_cmd_s mem_cmd_o
   , output logic              mem_cmd_v_o
   , input  logic              mem_cmd_ready_i

   // One pulse per response consumed by the response stage
   , input  logic              resp_done_i
  );

  localparam int cnt_width_lp = $clog2(max_outstanding_p + 1);

  typedef logic [cnt_width_lp-1:0] cnt_t;

  cce_pkg::cce_mode_e mode_r;
  cce_pkg::mem_cmd_s  mem_cmd_n;
  cnt_t               outstanding_r;
  logic [cnt_width_lp:0] outstanding_n;
  logic               cmd_xfer;
  logic               slot_free;
  logic               credit_ok;

  // Mode register, only the mode address is decoded
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mode_r <= cce_pkg::e_cce_mode_uncached;
    end else if (cfg_w_v_i && (cfg_addr_i == cce_pkg::cfg_mode_addr_c)) begin
      mode_r <= cce_pkg::cce_mode_e'(cfg_data_i[0]);
    end
  end

  assign cmd_xfer = mem_cmd_v_o & mem_cmd_ready_i;
  assign slot_free = ~mem_cmd_v_o | mem_cmd_ready_i;

  // Count after this cycle's transfer and completion
  assign outstanding_n = {1'b0, outstanding_r}
                         + {{cnt_width_lp{1'b0}}, cmd_xfer}
                         - {{cnt_width_lp{1'b0}}, resp_done_i};

  // A command taken now will transfer later, so it needs a spare credit
  assign credit_ok = (outstanding_n < (cnt_width_lp + 1)'(max_outstanding_p));

  assign lce_req_yumi_o = ~reset_i
                          & lce_req_v_i
                          & (mode_r == cce_pkg::e_cce_mode_uncached)
                          & slot_free
                          & credit_ok;

  // Request to memory command translation
  always_comb begin
    mem_cmd_n.addr = lce_req_i.addr;
    mem_cmd_n.payload = lce_req_i.src_id;
    if (lce_req_i.msg_type == cce_pkg::e_lce_req_uc_store) begin
      mem_cmd_n.msg = cce_pkg::e_mem_uc_wr;
      mem_cmd_n.data = lce_req_i.data;
    end else begin
      mem_cmd_n.msg = cce_pkg::e_mem_uc_rd;
      mem_cmd_n.data = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_cmd_v_o <= 1'b0;
    end else if (lce_req_yumi_o) begin
      mem_cmd_v_o <= 1'b1;
    end else if (mem_cmd_ready_i) begin
      mem_cmd_v_o <= 1'b0;
    end
  end

  // Payload holds while stalled
  always_ff @(posedge clk_i) begin
    if (lce_req_yumi_o) begin
      mem_cmd_o <= mem_cmd_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_r <= '0;
    end else begin
      outstanding_r <= outstanding_n[cnt_width_lp-1:0];
    end
  end

endmodule

`default_nettype wire

//--- cce_pkg.sv
// Widths, message types, mode enum, message structs and config address of the uncached CCE
`default_nettype none

package cce_pkg;

  localparam int paddr_width_c  = 32;
  localparam int dword_width_c  = 64;
  localparam int lce_id_width_c = 2;
  localparam int cce_id_width_c = 2;
  localparam int cfg_addr_width_c = 16;
  localparam int cfg_data_width_c = 32;

  typedef logic [paddr_width_c-1:0]    paddr_t;
  typedef logic [dword_width_c-1:0]    dword_t;
  typedef logic [lce_id_width_c-1:0]   lce_id_t;
  typedef logic [cce_id_width_c-1:0]   cce_id_t;
  typedef logic [cfg_addr_width_c-1:0] cfg_addr_t;
  typedef logic [cfg_data_width_c-1:0] cfg_data_t;

  // Mode register lives at this config address
  localparam cfg_addr_t cfg_mode_addr_c = 16'h0008;

  typedef enum logic [0:0] {
    e_cce_mode_uncached = 1'b0
    , e_cce_mode_normal = 1'b1
  } cce_mode_e;

  typedef enum logic [0:0] {
    e_lce_req_uc_load = 1'b0
    , e_lce_req_uc_store = 1'b1
  } lce_req_type_e;

  typedef enum logic [0:0] {
    e_mem_uc_rd = 1'b0
    , e_mem_uc_wr = 1'b1
  } mem_msg_e;

  typedef enum logic [0:0] {
    e_lce_cmd_uc_data = 1'b0
    , e_lce_cmd_uc_st_done = 1'b1
  } lce_cmd_type_e;

  // LCE to CCE request, 99 bits
  typedef struct packed {
    lce_id_t       src_id;
    lce_req_type_e msg_type;
    paddr_t        addr;
    dword_t        data;
  } lce_req_s;

  // CCE to memory command, 99 bits
  typedef struct packed {
    mem_msg_e msg;
    paddr_t   addr;
    dword_t   data;
    lce_id_t  payload;
  } mem_cmd_s;

  // Memory to CCE response, same layout as the command
  typedef struct packed {
    mem_msg_e msg;
    paddr_t   addr;
    dword_t   data;
    lce_id_t  payload;
  } mem_resp_s;

  // CCE to LCE command, 101 bits
  typedef struct packed {
    lce_id_t       dst_id;
    cce_id_t       src_id;
    lce_cmd_type_e msg_type;
    paddr_t        addr;
    dword_t        data;
  } lce_cmd_s;

endpackage

`default_nettype wire
